// File: arch_pkg.sv
package arch_pkg;

    // Architectural register width
    localparam int DATA_WIDTH = 32;

    // Number of general purpose registers, r0 included
    localparam int GPR_NUM = 32;

    // Register index width follows the register count
    localparam int REG_ADDR_WIDTH = $clog2(GPR_NUM);

    // Index into the general register file
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // One architectural register value
    typedef logic [DATA_WIDTH-1:0] reg_data_t;

endpackage

// File: rf_pkg.sv
package rf_pkg;

    // One bit covers two write banks
    localparam int BANK_IDX_WIDTH = 1;

    // Write bank that holds the live copy of a register
    typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;

    // Default port counts of the register file
    localparam int DEF_WRITE_PORTS = 2;
    localparam int DEF_READ_PORTS  = 4;

endpackage

// File: reg_lutram.sv
`timescale 1ns/10ps

module reg_lutram (
    input  logic               clk,

    // Write port
    input  logic               wen,
    input  arch_pkg::reg_addr_t waddr,
    input  arch_pkg::reg_data_t wdata,

    // Asynchronous read port
    input  arch_pkg::reg_addr_t raddr,
    output arch_pkg::reg_data_t rdata
);

    import arch_pkg::*;

    // Kept free of reset so it maps onto distributed RAM
    reg_data_t ram [GPR_NUM];

    always_ff @(posedge clk) begin
        if (wen) begin
            ram[waddr] <= wdata;
        end
    end

    assign rdata = ram[raddr];

endmodule

// File: last_valid_table.sv
`timescale 1ns/10ps

module last_valid_table #(
    parameter int WRITE_PORTS = 2,
    parameter int READ_PORTS  = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,

    // Write side, one entry per write port
    input  logic [WRITE_PORTS-1:0]                we_i,
    input  arch_pkg::reg_addr_t [WRITE_PORTS-1:0] waddr_i,

    // Lookup side, one entry per read port
    input  arch_pkg::reg_addr_t [READ_PORTS-1:0]  raddr_i,
    output rf_pkg::bank_idx_t [READ_PORTS-1:0]    rdata_o
);

    import arch_pkg::*;
    import rf_pkg::*;

    // Bank that holds the live value of each register
    bank_idx_t live_bank [GPR_NUM];

    // Later ports overwrite earlier ones, so the highest port wins on a clash
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                live_bank[i] <= '0;
            end
        end else begin
            for (int w = 0; w < WRITE_PORTS; w++) begin
                if (we_i[w]) begin
                    live_bank[waddr_i[w]] <= bank_idx_t'(w);
                end
            end
        end
    end

    // Lookups are combinational
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            rdata_o[r] = live_bank[raddr_i[r]];
        end
    end

endmodule

// File: regs_file.sv
`timescale 1ns/10ps

module regs_file #(
    parameter int WRITE_PORTS = 2,
    parameter int READ_PORTS  = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,

    // Write ports from writeback
    input  logic [WRITE_PORTS-1:0]                we_i,
    input  arch_pkg::reg_addr_t [WRITE_PORTS-1:0] waddr_i,
    input  arch_pkg::reg_data_t [WRITE_PORTS-1:0] wdata_i,

    // Read ports, data returns in the same cycle
    input  logic [READ_PORTS-1:0]                 read_valid_i,
    input  arch_pkg::reg_addr_t [READ_PORTS-1:0]  read_addr_i,
    output arch_pkg::reg_data_t [READ_PORTS-1:0]  read_data_o
);

    import arch_pkg::*;
    import rf_pkg::*;

    // Bank holding the live value for each read port
    bank_idx_t [READ_PORTS-1:0] bank_sel;

    // Raw bank outputs, indexed by write bank then read port
    reg_data_t [WRITE_PORTS-1:0][READ_PORTS-1:0] bank_rdata;

    last_valid_table #(
        .WRITE_PORTS(WRITE_PORTS),
        .READ_PORTS (READ_PORTS)
    ) u_lvt (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .we_i   (we_i),
        .waddr_i(waddr_i),
        .raddr_i(read_addr_i),
        .rdata_o(bank_sel)
    );

    // Each write port owns a bank, copied once per read port
    generate
        for (genvar w = 0; w < WRITE_PORTS; w++) begin : g_write_bank
            for (genvar r = 0; r < READ_PORTS; r++) begin : g_read_copy
                reg_lutram u_reg_lutram (
                    .clk  (clk),
                    .wen  (we_i[w]),
                    .waddr(waddr_i[w]),
                    .wdata(wdata_i[w]),
                    .raddr(read_addr_i[r]),
                    .rdata(bank_rdata[w][r])
                );
            end
        end
    endgenerate

    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            // Stored value from the bank that last wrote this register
            read_data_o[r] = bank_rdata[bank_sel[r]][r];

            // Same-cycle write forwards its data, highest port last
            for (int w = 0; w < WRITE_PORTS; w++) begin
                if (we_i[w] && (waddr_i[w] == read_addr_i[r])) begin
                    read_data_o[r] = wdata_i[w];
                end
            end

            // r0 reads as zero
            if (read_addr_i[r] == '0) begin
                read_data_o[r] = '0;
            end

            // Idle port gives zero
            if (!read_valid_i[r]) begin
                read_data_o[r] = '0;
            end
        end
    end

endmodule

// File: wb_stage.sv
`timescale 1ns/10ps

module wb_stage #(
    parameter int WRITE_PORTS = 2
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,

    // Commit streams from the execution pipes
    input  logic [WRITE_PORTS-1:0]                commit_valid_i,
    input  arch_pkg::reg_addr_t [WRITE_PORTS-1:0] commit_addr_i,
    input  arch_pkg::reg_data_t [WRITE_PORTS-1:0] commit_data_i,

    // Registered write requests to the register file
    output logic [WRITE_PORTS-1:0]                we_o,
    output arch_pkg::reg_addr_t [WRITE_PORTS-1:0] waddr_o,
    output arch_pkg::reg_data_t [WRITE_PORTS-1:0] wdata_o
);

    // Commits that actually update state, r0 excluded
    logic [WRITE_PORTS-1:0] commit_keep;

    always_comb begin
        for (int w = 0; w < WRITE_PORTS; w++) begin
            commit_keep[w] = commit_valid_i[w] && (commit_addr_i[w] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_o <= '0;
        end else begin
            we_o <= commit_keep;
        end
    end

    // Address and data follow the enable, no stall
    always_ff @(posedge clk) begin
        waddr_o <= commit_addr_i;
        wdata_o <= commit_data_i;
    end

endmodule

// File: regfile_top.sv
`timescale 1ns/10ps

module regfile_top #(
    parameter int WRITE_PORTS = rf_pkg::DEF_WRITE_PORTS,
    parameter int READ_PORTS  = rf_pkg::DEF_READ_PORTS
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,

    // Commit side
    input  logic [WRITE_PORTS-1:0]                commit_valid_i,
    input  arch_pkg::reg_addr_t [WRITE_PORTS-1:0] commit_addr_i,
    input  arch_pkg::reg_data_t [WRITE_PORTS-1:0] commit_data_i,

    // Read side
    input  logic [READ_PORTS-1:0]                 read_valid_i,
    input  arch_pkg::reg_addr_t [READ_PORTS-1:0]  read_addr_i,
    output arch_pkg::reg_data_t [READ_PORTS-1:0]  read_data_o
);

    import arch_pkg::*;

    // Writeback to register file
    logic [WRITE_PORTS-1:0]      wb_we;
    reg_addr_t [WRITE_PORTS-1:0] wb_waddr;
    reg_data_t [WRITE_PORTS-1:0] wb_wdata;

    wb_stage #(
        .WRITE_PORTS(WRITE_PORTS)
    ) u_wb_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .commit_valid_i(commit_valid_i),
        .commit_addr_i (commit_addr_i),
        .commit_data_i (commit_data_i),
        .we_o          (wb_we),
        .waddr_o       (wb_waddr),
        .wdata_o       (wb_wdata)
    );

    regs_file #(
        .WRITE_PORTS(WRITE_PORTS),
        .READ_PORTS (READ_PORTS)
    ) u_regs_file (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .we_i        (wb_we),
        .waddr_i     (wb_waddr),
        .wdata_i     (wb_wdata),
        .read_valid_i(read_valid_i),
        .read_addr_i (read_addr_i),
        .read_data_o (read_data_o)
    );

endmodule

// File: tb_regfile.sv
`timescale 1ns/10ps

module tb_regfile;

    import arch_pkg::*;
    import rf_pkg::*;

    localparam int WP           = DEF_WRITE_PORTS;
    localparam int RP           = DEF_READ_PORTS;
    localparam int CLK_HALF     = 50;
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int SAMPLE_DELAY = 80;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_LINES    = 64;
    localparam int NAME_CHARS   = 24;
    localparam int SWEEP_CYCLES = 2 * (GPR_NUM / 2) + GPR_NUM;

    logic               clk;
    logic               rst_n_i;
    logic [WP-1:0]      commit_valid;
    reg_addr_t [WP-1:0] commit_addr;
    reg_data_t [WP-1:0] commit_data;
    logic [RP-1:0]      read_valid;
    reg_addr_t [RP-1:0] read_addr;
    reg_data_t [RP-1:0] read_data;

    // Architectural state as seen by the read ports
    reg_data_t model_regs [GPR_NUM];

    // One entry per stimulus line
    logic [8*NAME_CHARS-1:0] stim_name   [MAX_LINES];
    logic [WP-1:0]           stim_cvalid [MAX_LINES];
    reg_addr_t [WP-1:0]      stim_caddr  [MAX_LINES];
    reg_data_t [WP-1:0]      stim_cdata  [MAX_LINES];
    logic [RP-1:0]           stim_rvalid [MAX_LINES];
    reg_addr_t [RP-1:0]      stim_raddr  [MAX_LINES];
    reg_data_t [RP-1:0]      stim_expect [MAX_LINES];
    int                      stim_count;

    bit     watchdog_armed;
    longint watchdog_ns;

    regfile_top #(
        .WRITE_PORTS(WP),
        .READ_PORTS (RP)
    ) dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .commit_valid_i(commit_valid),
        .commit_addr_i (commit_addr),
        .commit_data_i (commit_data),
        .read_valid_i  (read_valid),
        .read_addr_i   (read_addr),
        .read_data_o   (read_data)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic drive_idle();
        commit_valid = '0;
        commit_addr  = '0;
        commit_data  = '0;
        read_valid   = '0;
        read_addr    = '0;
    endtask

    function automatic reg_data_t model_read(input logic valid, input reg_addr_t addr);
        if (!valid || addr == '0) begin
            return '0;
        end
        return model_regs[addr];
    endfunction

    // Port order matters, the higher port lands last
    task automatic commit_to_model(input logic [WP-1:0] valid,
                                   input reg_addr_t [WP-1:0] addr,
                                   input reg_data_t [WP-1:0] data);
        for (int w = 0; w < WP; w++) begin
            if (valid[w] && addr[w] != '0) begin
                model_regs[addr[w]] = data[w];
            end
        end
    endtask

    task automatic load_stimulus();
        int                      fd;
        int                      fields;
        logic [8*256-1:0]        line_buf;
        logic [8*NAME_CHARS-1:0] name;
        logic [31:0]             field [18];
        fd = $fopen("regfile_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file regfile_stim.txt");
            abort_run();
        end
        stim_count = 0;
        while ($fgets(line_buf, fd) != 0) begin
            fields = $sscanf(line_buf,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, field[0], field[1], field[2], field[3], field[4], field[5],
                field[6], field[7], field[8], field[9], field[10], field[11],
                field[12], field[13], field[14], field[15], field[16], field[17]);
            // Comment and blank lines never yield a full record
            if (fields == 19) begin
                if (stim_count >= MAX_LINES) begin
                    $display("The stimulus file holds more than %0d lines", MAX_LINES);
                    abort_run();
                end
                stim_name[stim_count]      = name;
                stim_cvalid[stim_count][0] = field[0][0];
                stim_caddr[stim_count][0]  = reg_addr_t'(field[1]);
                stim_cdata[stim_count][0]  = field[2];
                stim_cvalid[stim_count][1] = field[3][0];
                stim_caddr[stim_count][1]  = reg_addr_t'(field[4]);
                stim_cdata[stim_count][1]  = field[5];
                for (int p = 0; p < RP; p++) begin
                    stim_rvalid[stim_count][p] = field[6 + 2 * p][0];
                    stim_raddr[stim_count][p]  = reg_addr_t'(field[7 + 2 * p]);
                    stim_expect[stim_count][p] = field[14 + p];
                end
                stim_count++;
            end
        end
        $fclose(fd);
        if (stim_count == 0) begin
            $display("The stimulus file holds no test lines");
            abort_run();
        end
    endtask

    task automatic check_against_model(input string name);
        reg_data_t expected;
        for (int p = 0; p < RP; p++) begin
            expected = model_read(read_valid[p], read_addr[p]);
            assert (read_data[p] === expected) else begin
                $display("Fail %s port %0d expected %h actual %h",
                         name, p, expected, read_data[p]);
                abort_run();
            end
        end
    endtask

    task automatic check_stim_line(input int idx);
        reg_data_t expected;
        for (int p = 0; p < RP; p++) begin
            expected = model_read(stim_rvalid[idx][p], stim_raddr[idx][p]);
            assert (stim_expect[idx][p] === expected) else begin
                $display("Fail %0s port %0d expected %h actual %h in the register model",
                         stim_name[idx], p, stim_expect[idx][p], expected);
                abort_run();
            end
            assert (read_data[p] === stim_expect[idx][p]) else begin
                $display("Fail %0s port %0d expected %h actual %h",
                         stim_name[idx], p, stim_expect[idx][p], read_data[p]);
                abort_run();
            end
        end
    endtask

    // Fill every register from both ports, then read each one on every port
    task automatic run_sweep();
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < GPR_NUM / 2; i++) begin
                @(posedge clk);
                #DRIVE_DELAY;
                read_valid     = '0;
                commit_valid   = '1;
                commit_addr[0] = reg_addr_t'(2 * i + pass);
                commit_addr[1] = reg_addr_t'(2 * i + 1 - pass);
                for (int w = 0; w < WP; w++) begin
                    commit_data[w] = $urandom();
                end
                // Idle reads aimed at the registers under write
                for (int p = 0; p < RP; p++) begin
                    read_addr[p] = commit_addr[p % WP];
                end
                #SAMPLE_DELAY;
                check_against_model("sweep_write");
                commit_to_model(commit_valid, commit_addr, commit_data);
            end
        end
        for (int c = 0; c < GPR_NUM; c++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            commit_valid = '0;
            read_valid   = '1;
            for (int p = 0; p < RP; p++) begin
                read_addr[p] = reg_addr_t'((c + p * (GPR_NUM / RP)) % GPR_NUM);
            end
            #SAMPLE_DELAY;
            check_against_model("sweep_read");
        end
    endtask

    task automatic run_stim();
        for (int idx = 0; idx < stim_count; idx++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            commit_valid = stim_cvalid[idx];
            commit_addr  = stim_caddr[idx];
            commit_data  = stim_cdata[idx];
            read_valid   = stim_rvalid[idx];
            read_addr    = stim_raddr[idx];
            #SAMPLE_DELAY;
            check_stim_line(idx);
            commit_to_model(stim_cvalid[idx], stim_caddr[idx], stim_cdata[idx]);
        end
    endtask

    initial begin
        wait (watchdog_armed);
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        abort_run();
    end

    initial begin
        void'($urandom(77));
        rst_n_i = 1'b0;
        drive_idle();
        load_stimulus();
        watchdog_ns = longint'(RESET_CYCLES + SWEEP_CYCLES + stim_count + 20) * CLK_PERIOD;
        watchdog_armed = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        run_sweep();
        run_stim();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: regfile_stim.txt
# Columns: name, commit0 valid addr data, commit1 valid addr data,
# then read valid and addr for ports 0 to 3, then expected read data of ports 0 to 3 (hex)
init_wr 1 01 11111111 1 02 22222222 0 00 0 00 0 00 0 00 00000000 00000000 00000000 00000000
byp_rd 0 00 00000000 0 00 00000000 1 01 1 02 1 01 1 02 11111111 22222222 11111111 22222222
held_rd 0 00 00000000 0 00 00000000 1 01 1 02 1 01 1 02 11111111 22222222 11111111 22222222
dual_wr 1 03 aaaa0000 1 03 bbbb1111 1 01 1 02 1 00 0 03 11111111 22222222 00000000 00000000
dual_byp 0 00 00000000 0 00 00000000 1 03 1 03 1 03 1 03 bbbb1111 bbbb1111 bbbb1111 bbbb1111
dual_held 0 00 00000000 0 00 00000000 1 03 1 03 1 03 1 03 bbbb1111 bbbb1111 bbbb1111 bbbb1111
r0_wr 1 00 deadbeef 1 04 44444444 1 00 1 03 1 00 1 01 00000000 bbbb1111 00000000 11111111
r0_byp 0 00 00000000 0 00 00000000 1 00 1 00 1 00 1 04 00000000 00000000 00000000 44444444
r0_held 0 00 00000000 0 00 00000000 1 00 1 00 1 04 1 00 00000000 00000000 44444444 00000000
idle_rd 0 00 00000000 0 00 00000000 0 01 0 02 0 03 0 04 00000000 00000000 00000000 00000000
idle_mix 0 00 00000000 0 00 00000000 1 01 0 02 1 03 0 04 11111111 00000000 bbbb1111 00000000
alt_0 1 05 50000000 0 00 00000000 0 05 0 05 0 05 0 05 00000000 00000000 00000000 00000000
alt_1 0 00 00000000 1 05 51111111 1 05 1 05 1 05 1 05 50000000 50000000 50000000 50000000
alt_2 1 05 52222222 0 00 00000000 1 05 1 05 1 05 1 05 51111111 51111111 51111111 51111111
alt_3 0 00 00000000 1 05 53333333 1 05 1 05 1 05 1 05 52222222 52222222 52222222 52222222
alt_4 1 05 54444444 0 00 00000000 1 05 1 05 1 05 1 05 53333333 53333333 53333333 53333333
alt_5 0 00 00000000 1 05 55555555 1 05 1 05 1 05 1 05 54444444 54444444 54444444 54444444
alt_byp 0 00 00000000 0 00 00000000 1 05 1 05 1 05 1 05 55555555 55555555 55555555 55555555
alt_held 0 00 00000000 0 00 00000000 1 05 1 05 1 05 1 05 55555555 55555555 55555555 55555555
dual_wr_b 1 06 60000006 1 06 61111116 1 05 1 05 1 01 1 02 55555555 55555555 11111111 22222222
dual_byp_b 1 07 70000007 0 00 00000000 1 06 1 06 1 06 1 06 61111116 61111116 61111116 61111116
dual_held_b 0 00 00000000 0 00 00000000 1 06 1 07 1 06 1 07 61111116 70000007 61111116 70000007
over_wr 1 06 6000aaaa 0 00 00000000 1 06 1 06 1 07 1 07 61111116 61111116 70000007 70000007
over_byp 0 00 00000000 0 00 00000000 1 06 1 06 1 06 1 06 6000aaaa 6000aaaa 6000aaaa 6000aaaa
over_held 0 00 00000000 0 00 00000000 1 06 1 06 1 07 1 00 6000aaaa 6000aaaa 70000007 00000000
stream_0 1 08 80000008 1 09 90000009 1 01 1 02 1 03 1 04 11111111 22222222 bbbb1111 44444444
stream_1 1 0a a000000a 1 0b b000000b 1 08 1 09 1 08 1 09 80000008 90000009 80000008 90000009
stream_2 1 0c c000000c 1 0d d000000d 1 0a 1 0b 1 08 1 09 a000000a b000000b 80000008 90000009
stream_3 0 00 00000000 0 00 00000000 1 0c 1 0d 1 0a 1 0b c000000c d000000d a000000a b000000b
stream_4 0 00 00000000 0 00 00000000 1 0c 1 0d 1 08 1 09 c000000c d000000d 80000008 90000009
no_valid 0 01 ffffffff 0 02 eeeeeeee 1 01 1 02 1 05 1 06 11111111 22222222 55555555 6000aaaa
no_valid_chk 0 00 00000000 0 00 00000000 1 01 1 02 1 01 1 02 11111111 22222222 11111111 22222222
top_wr 1 1e e000001e 1 1f f000001f 0 1f 0 1e 0 1f 0 1e 00000000 00000000 00000000 00000000
top_byp 0 00 00000000 0 00 00000000 1 1e 1 1f 1 1e 1 1f e000001e f000001f e000001e f000001f
top_held 0 00 00000000 0 00 00000000 1 1f 1 1e 1 00 1 1f f000001f e000001e 00000000 f000001f
dual_r0 1 00 12345678 1 00 87654321 1 00 1 00 1 00 1 00 00000000 00000000 00000000 00000000
dual_r0_byp 0 00 00000000 0 00 00000000 1 00 1 00 1 00 1 00 00000000 00000000 00000000 00000000
idle_r0 0 00 00000000 0 00 00000000 0 00 1 1f 0 1e 1 00 00000000 f000001f 00000000 00000000
final_rd 0 00 00000000 0 00 00000000 1 03 1 05 1 06 1 0d bbbb1111 55555555 6000aaaa d000000d

// File: build.f
arch_pkg.sv
rf_pkg.sv
reg_lutram.sv
last_valid_table.sv
regs_file.sv
wb_stage.sv
regfile_top.sv
tb_regfile.sv
